/* Makefile */
# Verilator simulation of the cartridge loader

TOP := cart_loader_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* flist.f */
source/cart_pkg.sv
source/rom_header_detect.sv
source/cheat_code_loader.sv
source/backup_sequencer.sv
source/cart_loader_top.sv
test/cart_loader_assert.sv
test/cart_loader_tb.sv

/* source/backup_sequencer.sv */
// Backup-RAM sequencer: save tracking, load and save triggers, sector walk to the storage host
`timescale 1ns/1ns

module backup_sequencer #(
	parameter int SECTOR_SHIFT = 9
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_download,
	input  logic [cart_pkg::mask_w-1:0] ram_mask,
	input  logic                        osd_open,
	input  logic                        bk_load,
	input  logic                        bk_save,
	input  logic                        autosave,
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic                        img_size_nonzero,
	input  logic                        bsram_write,
	input  logic                        sd_ack,
	output logic [cart_pkg::lba_w-1:0]  sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic                        busy,
	output logic                        loading,
	output logic                        save_pending,
	output logic                        backup_enable
);

	localparam int lw = cart_pkg::lba_w;
	localparam int mw = cart_pkg::mask_w;

	cart_pkg::bk_state_t state;

	logic          dl_q;
	logic          load_q;
	logic          save_q;
	logic          ack_q;
	logic          save_req;
	logic          idle;
	logic          dl_end;
	logic          ack_rise;
	logic          ack_fall;
	logic          start_load;
	logic          start_save;
	logic [lw-1:0] last_sector;

	// ================================================
	// Edge detection
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			dl_q   <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			dl_q   <= cart_download;
			load_q <= bk_load;
			save_q <= save_req;
			ack_q  <= sd_ack;
		end
	end

	// Autosave fires when the menu opens with unsaved data
	assign save_req = bk_save | (save_pending & osd_open & autosave);

	assign idle     = (state == cart_pkg::bk_idle);
	assign dl_end   = dl_q & ~cart_download;
	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ack_q & ~sd_ack;

	assign start_load = idle & backup_enable & ((bk_load & ~load_q) | (dl_end & img_size_nonzero));
	assign start_save = idle & backup_enable & save_req & ~save_q & ~start_load;

	assign last_sector = {{(lw - mw){1'b0}}, ram_mask >> SECTOR_SHIFT};

	// ================================================
	// Save-file status
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			backup_enable <= 1'b0;
		end else begin
			if (cart_download && !dl_q) begin
				backup_enable <= 1'b0;
			end
			// Save image is mounted by the end of the download
			if (cart_download && img_mounted && !img_readonly) begin
				backup_enable <= |ram_mask;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			save_pending <= 1'b0;
		end else if (backup_enable && !osd_open && bsram_write) begin
			save_pending <= 1'b1;
		end else if (!idle) begin
			save_pending <= 1'b0;
		end
	end

	// ================================================
	// Sector walk
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state   <= cart_pkg::bk_idle;
			loading <= 1'b0;
			sd_lba  <= '0;
		end else begin
			case (state)
				cart_pkg::bk_idle: begin
					if (start_load || start_save) begin
						state   <= cart_pkg::bk_request;
						loading <= start_load;
						sd_lba  <= '0;
					end
				end
				cart_pkg::bk_request: begin
					// Host has taken the sector request
					if (ack_rise) begin
						state <= cart_pkg::bk_wait_done;
					end
				end
				cart_pkg::bk_wait_done: begin
					if (ack_fall) begin
						if (sd_lba >= last_sector) begin
							state   <= cart_pkg::bk_idle;
							loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + lw'(1);
							state  <= cart_pkg::bk_request;
						end
					end
				end
				default: state <= cart_pkg::bk_idle;
			endcase
		end
	end

	assign busy  = ~idle;
	assign sd_rd = (state == cart_pkg::bk_request) & loading;
	assign sd_wr = (state == cart_pkg::bk_request) & ~loading;

endmodule

/* source/cart_loader_top.sv */
// Cartridge loader top level: download index decode, header detection, cheats and backup RAM
`timescale 1ns/1ns

module cart_loader_top #(
	parameter logic [7:0] CODE_INDEX   = 8'hFF,
	parameter int         SECTOR_SHIFT = 9
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        ioctl_download,
	input  logic [7:0]                  ioctl_index,
	input  logic [cart_pkg::addr_w-1:0] ioctl_addr,
	input  logic                        ioctl_wr,
	input  logic [15:0]                 ioctl_data,
	input  cart_pkg::header_mode_t      header_mode,
	input  cart_pkg::region_sel_t       region_sel,
	input  logic                        osd_open,
	input  logic                        bk_load,
	input  logic                        bk_save,
	input  logic                        autosave,
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic                        img_size_nonzero,
	input  logic                        bsram_write,
	input  logic                        sd_ack,
	output logic [7:0]                  rom_type,
	output logic [cart_pkg::mask_w-1:0] rom_mask,
	output logic [cart_pkg::mask_w-1:0] ram_mask,
	output logic                        pal,
	output logic [cart_pkg::code_w-1:0] cheat_code,
	output logic                        code_strobe,
	output logic                        cheat_clear,
	output logic [cart_pkg::lba_w-1:0]  sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic                        busy,
	output logic                        loading,
	output logic                        save_pending,
	output logic                        backup_enable
);

	logic code_index;
	logic cart_download;
	logic code_download;

	// ================================================
	// Download routing
	// ================================================

	// Cheat files use a dedicated index, everything else is a cartridge
	assign code_index    = (ioctl_index == CODE_INDEX);
	assign cart_download = ioctl_download & ~code_index;
	assign code_download = ioctl_download & code_index;

	rom_header_detect i_header (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ioctl_addr    (ioctl_addr),
		.ioctl_wr      (ioctl_wr),
		.ioctl_data    (ioctl_data),
		.header_mode   (header_mode),
		.region_sel    (region_sel),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	cheat_code_loader i_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.code_download (code_download),
		.ioctl_addr    (ioctl_addr),
		.ioctl_wr      (ioctl_wr),
		.ioctl_data    (ioctl_data),
		.cheat_code    (cheat_code),
		.code_strobe   (code_strobe),
		.cheat_clear   (cheat_clear)
	);

	// Save RAM size comes from the detected header
	backup_sequencer #(
		.SECTOR_SHIFT (SECTOR_SHIFT)
	) i_backup (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.cart_download    (cart_download),
		.ram_mask         (ram_mask),
		.osd_open         (osd_open),
		.bk_load          (bk_load),
		.bk_save          (bk_save),
		.autosave         (autosave),
		.img_mounted      (img_mounted),
		.img_readonly     (img_readonly),
		.img_size_nonzero (img_size_nonzero),
		.bsram_write      (bsram_write),
		.sd_ack           (sd_ack),
		.sd_lba           (sd_lba),
		.sd_rd            (sd_rd),
		.sd_wr            (sd_wr),
		.busy             (busy),
		.loading          (loading),
		.save_pending     (save_pending),
		.backup_enable    (backup_enable)
	);

endmodule

/* source/cart_pkg.sv */
// Shared widths, header address constants and enum types for the cartridge loader
package cart_pkg;

	// ================================================
	// Bus and record widths
	// ================================================

	// Byte address of the download stream
	localparam int addr_w = 25;

	// ROM and save-RAM address masks
	localparam int mask_w = 24;

	// Storage sector number
	localparam int lba_w = 32;

	// Strobe bit, flags, address, compare, replace
	localparam int code_w = 129;

	// ================================================
	// Image header layout
	// ================================================

	// Copier header in front of the image
	localparam logic [addr_w-1:0] header_skip = addr_w'(512);

	// Size byte of the internal header, RAM-size byte sits two bytes later
	localparam logic [addr_w-1:0] lorom_info_addr   = addr_w'(32'h0000_7FD6);
	localparam logic [addr_w-1:0] hirom_info_addr   = addr_w'(32'h0000_FFD6);
	localparam logic [addr_w-1:0] exhirom_info_addr = addr_w'(32'h0040_FFD6);

	// ================================================
	// Enumerations
	// ================================================

	// Menu choice for the ROM header
	typedef enum logic [2:0] {
		header_auto,
		header_none,
		header_lorom,
		header_hirom,
		header_exhirom
	} header_mode_t;

	// Video region override
	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal
	} region_sel_t;

	// Backup-RAM sector sequencer
	typedef enum logic [1:0] {
		bk_idle,
		bk_request,
		bk_wait_done
	} bk_state_t;

endpackage

/* source/cheat_code_loader.sv */
// Cheat-code loader: word assembly into code records, record strobe and cheat clear
`timescale 1ns/1ns

module cheat_code_loader (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_download,
	input  logic                        code_download,
	input  logic [cart_pkg::addr_w-1:0] ioctl_addr,
	input  logic                        ioctl_wr,
	input  logic [15:0]                 ioctl_data,
	output logic [cart_pkg::code_w-1:0] cheat_code,
	output logic                        code_strobe,
	output logic                        cheat_clear
);

	localparam int cw = cart_pkg::code_w;

	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	logic [cw-2:0] code_q;
	logic          strobe_q;
	logic          clear_q;
	logic          code_wr;

	assign code_wr = code_download & ioctl_wr;

	// Record fields, low word first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  code_q[111:96]  <= ioctl_data;
				4'd2:  code_q[127:112] <= ioctl_data;
				4'd4:  code_q[79:64]   <= ioctl_data;
				4'd6:  code_q[95:80]   <= ioctl_data;
				4'd8:  code_q[47:32]   <= ioctl_data;
				4'd10: code_q[63:48]   <= ioctl_data;
				4'd12: code_q[15:0]    <= ioctl_data;
				4'd14: code_q[31:16]   <= ioctl_data;
				default: ;
			endcase
		end
	end

	// Last word of a record releases it
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			strobe_q <= 1'b0;
			clear_q  <= 1'b0;
		end else begin
			strobe_q <= code_wr && ioctl_addr[3:0] == 4'd14;
			clear_q  <= code_wr && ioctl_addr == '0;
		end
	end

	assign cheat_code  = {strobe_q, code_q};
	assign code_strobe = strobe_q;

	// A new cheat file or a new cartridge drops the old codes
	assign cheat_clear = clear_q | cart_download;

endmodule

/* source/rom_header_detect.sv */
// ROM header detection: mapping type, ROM and RAM sizes, memory masks and video region
`timescale 1ns/1ns

module rom_header_detect (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_download,
	input  logic [cart_pkg::addr_w-1:0] ioctl_addr,
	input  logic                        ioctl_wr,
	input  logic [15:0]                 ioctl_data,
	input  cart_pkg::header_mode_t      header_mode,
	input  cart_pkg::region_sel_t       region_sel,
	output logic [7:0]                  rom_type,
	output logic [cart_pkg::mask_w-1:0] rom_mask,
	output logic [cart_pkg::mask_w-1:0] ram_mask,
	output logic                        pal
);

	localparam int aw = cart_pkg::addr_w;
	localparam int mw = cart_pkg::mask_w;

	logic [3:0]    rom_size;
	logic [3:0]    ram_size;
	logic          hdr_region;
	logic          wr_en;
	logic          forced;
	logic [aw-1:0] info_base;
	logic [aw-1:0] size_addr;
	logic [aw-1:0] ramsz_addr;

	assign wr_en = cart_download & ioctl_wr;

	// ================================================
	// Forced header location
	// ================================================

	always_comb begin
		forced    = 1'b1;
		info_base = cart_pkg::lorom_info_addr;
		case (header_mode)
			cart_pkg::header_lorom:   info_base = cart_pkg::lorom_info_addr;
			cart_pkg::header_hirom:   info_base = cart_pkg::hirom_info_addr;
			cart_pkg::header_exhirom: info_base = cart_pkg::exhirom_info_addr;
			default:                  forced    = 1'b0;
		endcase
	end

	// Offsets are given without the copier header
	assign size_addr  = info_base + cart_pkg::header_skip;
	assign ramsz_addr = size_addr + aw'(2);

	// ================================================
	// Header registers
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_type   <= 8'd0;
			rom_size   <= 4'd0;
			ram_size   <= 4'd0;
			hdr_region <= 1'b0;
		end else if (wr_en) begin
			if (ioctl_addr == '0) begin
				rom_size <= 4'hC;
				ram_size <= 4'h0;
				// Copier header packs both sizes into one byte
				if (header_mode == cart_pkg::header_auto && ioctl_data[7:0] != 8'h00) begin
					ram_size <= ioctl_data[7:4];
					rom_size <= ioctl_data[3:0];
				end
				case (header_mode)
					cart_pkg::header_none:    rom_type <= 8'd0;
					cart_pkg::header_lorom:   rom_type <= 8'd0;
					cart_pkg::header_hirom:   rom_type <= 8'd1;
					cart_pkg::header_exhirom: rom_type <= 8'd2;
					default:                  rom_type <= ioctl_data[15:8];
				endcase
			end

			if (ioctl_addr == aw'(2)) begin
				hdr_region <= ioctl_data[8];
			end

			// Internal header overrides the defaults set at address 0
			if (forced && ioctl_addr == size_addr) begin
				rom_size <= ioctl_data[11:8];
			end
			if (forced && ioctl_addr == ramsz_addr) begin
				ram_size <= ioctl_data[3:0];
			end
		end
	end

	// Sizes count in KiB powers of two
	assign rom_mask = (mw'(1024) << rom_size) - mw'(1);
	assign ram_mask = (ram_size == 4'd0) ? '0 : (mw'(1024) << ram_size) - mw'(1);

	// Region only follows the menu outside a download
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			pal <= 1'b0;
		end else if (!cart_download) begin
			case (region_sel)
				cart_pkg::region_ntsc: pal <= 1'b0;
				cart_pkg::region_pal:  pal <= 1'b1;
				default:               pal <= hdr_region;
			endcase
		end
	end

endmodule

/* test/cart_loader_assert.sv */
// Storage-host handshake, request exclusivity, cheat strobe width and sector range assertions
`timescale 1ns/1ns

module cart_loader_assert #(
	parameter int SECTOR_SHIFT = 9
) (
	input logic                        clk_sys,
	input logic                        reset,
	input logic                        sd_rd,
	input logic                        sd_wr,
	input logic                        sd_ack,
	input logic                        busy,
	input logic                        code_strobe,
	input logic [cart_pkg::lba_w-1:0]  sd_lba,
	input logic [cart_pkg::mask_w-1:0] ram_mask
);

	localparam int lw = cart_pkg::lba_w;

	int            fail_count = 0;
	logic [lw-1:0] last_sector;

	assign last_sector = lw'(ram_mask >> SECTOR_SHIFT);

	// ================================================
	// Storage host handshake
	// ================================================

	// Request stays up until the host answers
	req_held: assert property (@(posedge clk_sys) disable iff (!reset)
		((sd_rd || sd_wr) && !sd_ack) |=> (sd_rd || sd_wr))
		else begin
			fail_count = fail_count + 1;
			$error("sector request dropped before sd_ack");
		end

	req_exclusive: assert property (@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr))
		else begin
			fail_count = fail_count + 1;
			$error("sd_rd and sd_wr high together");
		end

	// Request is released right after the acknowledge
	req_release: assert property (@(posedge clk_sys) disable iff (!reset)
		$rose(sd_ack) |=> (!sd_rd && !sd_wr))
		else begin
			fail_count = fail_count + 1;
			$error("sector request still high after sd_ack rose");
		end

	lba_range: assert property (@(posedge clk_sys) disable iff (!reset)
		busy |-> (sd_lba <= last_sector))
		else begin
			fail_count = fail_count + 1;
			$error("sd_lba beyond the last save sector");
		end

	// ================================================
	// Cheat records
	// ================================================

	strobe_width: assert property (@(posedge clk_sys) disable iff (!reset)
		code_strobe |=> !code_strobe)
		else begin
			fail_count = fail_count + 1;
			$error("code_strobe longer than one cycle");
		end

endmodule

bind cart_loader_top cart_loader_assert #(
	.SECTOR_SHIFT (SECTOR_SHIFT)
) i_assert (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.sd_rd       (sd_rd),
	.sd_wr       (sd_wr),
	.sd_ack      (sd_ack),
	.busy        (busy),
	.code_strobe (code_strobe),
	.sd_lba      (sd_lba),
	.ram_mask    (ram_mask)
);

/* test/cart_loader_tb.sv */
// Cartridge loader testbench: clock, reset, LFSR, download tasks, storage-host model, checks
`timescale 1ns/1ns

module cart_loader_tb;

	localparam int aw = cart_pkg::addr_w;

	logic                        clk_sys;
	logic                        reset;
	logic                        ioctl_download;
	logic [7:0]                  ioctl_index;
	logic [aw-1:0]               ioctl_addr;
	logic                        ioctl_wr;
	logic [15:0]                 ioctl_data;
	cart_pkg::header_mode_t      header_mode;
	cart_pkg::region_sel_t       region_sel;
	logic                        osd_open;
	logic                        bk_load;
	logic                        bk_save;
	logic                        autosave;
	logic                        img_mounted;
	logic                        img_readonly;
	logic                        img_size_nonzero;
	logic                        bsram_write;
	logic                        sd_ack = 1'b0;
	logic [7:0]                  rom_type;
	logic [cart_pkg::mask_w-1:0] rom_mask;
	logic [cart_pkg::mask_w-1:0] ram_mask;
	logic                        pal;
	logic [cart_pkg::code_w-1:0] cheat_code;
	logic                        code_strobe;
	logic                        cheat_clear;
	logic [cart_pkg::lba_w-1:0]  sd_lba;
	logic                        sd_rd;
	logic                        sd_wr;
	logic                        busy;
	logic                        loading;
	logic                        save_pending;
	logic                        backup_enable;

	logic [31:0] data_lfsr = 32'h8f2d;
	logic [31:0] host_lfsr = 32'h8f2d;
	logic [31:0] served_lba [$];
	logic        served_rd [$];
	int          strobe_count = 0;

	cart_loader_top i_dut (.*);

	always #20 clk_sys = ~clk_sys;

	// ================================================
	// Helpers
	// ================================================

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, inout logic [31:0] state, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			v = {v[30:0], state[0]};
		end
	endtask

	// Mask for a size in KiB powers of two
	function automatic logic [63:0] kib_mask(input int size);
		return (64'd1024 << size) - 64'd1;
	endfunction

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			report_failure($sformatf("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	task automatic write_word(input logic [aw-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		#2;
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		@(posedge clk_sys);
		#2;
		ioctl_wr   = 1'b0;
	endtask

	task automatic start_download(input logic [7:0] index);
		@(posedge clk_sys);
		#2;
		ioctl_index    = index;
		ioctl_download = 1'b1;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		#2;
		ioctl_download = 1'b0;
	endtask

	task automatic wait_for_busy(input logic level);
		int n;
		n = 0;
		while (busy !== level) begin
			@(posedge clk_sys);
			#2;
			n++;
			if (n > 2000) begin
				report_failure($sformatf("Timeout waiting for busy to become %0b", level));
			end
		end
	endtask

	// Storage host: random answer delay, two-cycle acknowledge
	always begin : storage_host
		logic [31:0] delay;
		@(posedge clk_sys);
		#2;
		if (sd_rd || sd_wr) begin
			served_lba.push_back(sd_lba);
			served_rd.push_back(sd_rd);
			take_bits(3, host_lfsr, delay);
			repeat (delay + 1) @(posedge clk_sys);
			#2;
			sd_ack = 1'b1;
			repeat (2) @(posedge clk_sys);
			#2;
			sd_ack = 1'b0;
		end
	end

	always @(negedge clk_sys) begin
		if (code_strobe === 1'b1) begin
			strobe_count = strobe_count + 1;
		end
		if (i_dut.i_assert.fail_count != 0) begin
			report_failure("A protocol assertion on the DUT failed");
		end
	end

	// ================================================
	// Stimulus
	// ================================================

	initial begin
		logic [15:0]   first_word;
		logic [31:0]   field [4];
		logic [aw-1:0] info_addr;
		int            base;
		int            last;
		clk_sys          = 1'b0;
		reset            = 1'b0;
		ioctl_download   = 1'b0;
		ioctl_index      = 8'h00;
		ioctl_addr       = '0;
		ioctl_wr         = 1'b0;
		ioctl_data       = 16'h0000;
		header_mode      = cart_pkg::header_auto;
		region_sel       = cart_pkg::region_auto;
		osd_open         = 1'b0;
		bk_load          = 1'b0;
		bk_save          = 1'b0;
		autosave         = 1'b0;
		img_mounted      = 1'b0;
		img_readonly     = 1'b0;
		img_size_nonzero = 1'b0;
		bsram_write      = 1'b0;
		repeat (16) @(posedge clk_sys);
		#2;
		reset = 1'b1;
		check_value("busy", 64'(busy), 64'd0);
		check_value("cheat_clear", 64'(cheat_clear), 64'd0);

		// Auto header, sizes and type from the first word
		first_word = 16'h213A;
		start_download(8'h00);
		write_word(25'd0, first_word);
		check_value("cheat_clear", 64'(cheat_clear), 64'd1);
		write_word(25'd2, 16'h0100);
		check_value("rom_type", 64'(rom_type), 64'(first_word[15:8]));
		check_value("rom_mask", 64'(rom_mask), kib_mask(int'(first_word[3:0])));
		check_value("ram_mask", 64'(ram_mask), kib_mask(int'(first_word[7:4])));
		end_download();
		@(posedge clk_sys);
		#2;
		check_value("pal", 64'(pal), 64'd1);
		region_sel = cart_pkg::region_ntsc;
		@(posedge clk_sys);
		#2;
		check_value("pal", 64'(pal), 64'd0);
		region_sel = cart_pkg::region_auto;

		// Forced HiROM with no save RAM
		header_mode      = cart_pkg::header_hirom;
		img_mounted      = 1'b1;
		img_size_nonzero = 1'b1;
		info_addr        = cart_pkg::hirom_info_addr + cart_pkg::header_skip;
		start_download(8'h00);
		write_word(25'd0, 16'h55AA);
		write_word(info_addr, 16'h0B00);
		write_word(info_addr + aw'(2), 16'h0000);
		check_value("rom_type", 64'(rom_type), 64'd1);
		check_value("rom_mask", 64'(rom_mask), kib_mask(11));
		check_value("ram_mask", 64'(ram_mask), 64'd0);
		end_download();
		@(posedge clk_sys);
		#2;
		check_value("backup_enable", 64'(backup_enable), 64'd0);
		check_value("busy", 64'(busy), 64'd0);
		header_mode = cart_pkg::header_auto;

		// Two cheat records, low word of each field first
		start_download(8'hFF);
		for (int r = 0; r < 2; r++) begin
			for (int k = 0; k < 4; k++) begin
				take_bits(32, data_lfsr, field[k]);
			end
			for (int k = 0; k < 4; k++) begin
				write_word(aw'(r * 16 + 4 * k), field[k][15:0]);
				if (k == 0) begin
					check_value("cheat_clear", 64'(cheat_clear), (r == 0) ? 64'd1 : 64'd0);
				end
				write_word(aw'(r * 16 + 4 * k + 2), field[k][31:16]);
			end
			check_value("code_strobe", 64'(code_strobe), 64'd1);
			check_value("cheat_code[128]", 64'(cheat_code[128]), 64'd1);
			check_value("cheat_code[127:96]", 64'(cheat_code[127:96]), 64'(field[0]));
			check_value("cheat_code[95:64]", 64'(cheat_code[95:64]), 64'(field[1]));
			check_value("cheat_code[63:32]", 64'(cheat_code[63:32]), 64'(field[2]));
			check_value("cheat_code[31:0]", 64'(cheat_code[31:0]), 64'(field[3]));
			@(posedge clk_sys);
			#2;
		end
		check_value("strobe_count", 64'(strobe_count), 64'd2);
		end_download();

		// RAM size 1 gives four sectors, loaded after the download
		start_download(8'h00);
		write_word(25'd0, 16'h0019);
		write_word(25'd2, 16'h0000);
		check_value("backup_enable", 64'(backup_enable), 64'd1);
		base = served_lba.size();
		last = int'(kib_mask(1) >> 9);
		end_download();
		wait_for_busy(1'b1);
		check_value("loading", 64'(loading), 64'd1);
		wait_for_busy(1'b0);
		check_value("loading", 64'(loading), 64'd0);
		check_value("load sectors", 64'(served_lba.size() - base), 64'(last + 1));
		for (int i = 0; i <= last; i++) begin
			check_value("load sd_lba", 64'(served_lba[base + i]), 64'(i));
			check_value("load sd_rd", 64'(served_rd[base + i]), 64'd1);
		end

		// Autosave once the menu opens
		@(posedge clk_sys);
		#2;
		bsram_write = 1'b1;
		@(posedge clk_sys);
		#2;
		bsram_write = 1'b0;
		check_value("save_pending", 64'(save_pending), 64'd1);
		base     = served_lba.size();
		autosave = 1'b1;
		osd_open = 1'b1;
		wait_for_busy(1'b1);
		check_value("loading", 64'(loading), 64'd0);
		wait_for_busy(1'b0);
		check_value("save_pending", 64'(save_pending), 64'd0);
		check_value("save sectors", 64'(served_lba.size() - base), 64'(last + 1));
		for (int i = 0; i <= last; i++) begin
			check_value("save sd_lba", 64'(served_lba[base + i]), 64'(i));
			check_value("save sd_rd", 64'(served_rd[base + i]), 64'd0);
		end
		osd_open = 1'b0;
		repeat (4) @(posedge clk_sys);

		if (i_dut.i_assert.fail_count != 0) begin
			report_failure("A protocol assertion on the DUT failed");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule
